//--- Makefile
SIM := obj_dir/Vxc_tb
SRCS := $(filter-out +%,$(shell cat vlog.f)) design/xc_defines.svh

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module xc_tb -Mdir obj_dir -o Vxc_tb

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "RESULT: FAIL" sim.log || ! grep -q "RESULT: PASS" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- design/correlator_core.sv
/*
 * Lag-zero intensity correlator.
 * A start pulse clears all counters and opens a window of integ_len cycles
 * (one cycle for a length of zero). Inside the window each line counts its
 * pulses and each line pair counts the cycles where both lines pulse.
 * Counters saturate at their maximum and the counts hold after the window.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module correlator_core (
	input  logic                                   intclk,
	input  logic                                   rst_n,
	input  logic                                   start,
	input  xc_pkg::len_t                           integ_len,
	input  xc_pkg::line_mask_t                     pulse,
	output logic                                   busy,
	output logic                                   done,
	output logic                                   saturated,
	output xc_pkg::count_t [`XC_NUM_LINES-1:0]     line_counts,
	output xc_pkg::count_t [`XC_NUM_BASELINES-1:0] base_counts
);
	import xc_pkg::*;

	len_t                        remain;
	logic [`XC_NUM_BASELINES-1:0] base_hit;
	logic [`XC_NUM_LINES-1:0]     line_full;
	logic [`XC_NUM_BASELINES-1:0] base_full;
	logic                        any_full;

	// pairs in order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	for (genvar a = 0; a < `XC_NUM_LINES; a++) begin : g_pair_a
		for (genvar b = a + 1; b < `XC_NUM_LINES; b++) begin : g_pair_b
			localparam int bl_idx = a * (2 * `XC_NUM_LINES - a - 1) / 2 + (b - a - 1);
			assign base_hit[bl_idx] = pulse[a] & pulse[b];
		end
	end

	always_comb begin
		for (int i = 0; i < `XC_NUM_LINES; i++) begin
			line_full[i] = &line_counts[i];
		end
		for (int k = 0; k < `XC_NUM_BASELINES; k++) begin
			base_full[k] = &base_counts[k];
		end
	end

	assign any_full = (|line_full) | (|base_full);

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			saturated <= 1'b0;
			remain <= '0;
			line_counts <= '0;
			base_counts <= '0;
		end else if (start && !busy) begin
			busy <= 1'b1;
			done <= 1'b0;
			saturated <= 1'b0;
			remain <= (integ_len == '0) ? '0 : integ_len - 1'b1; // zero means one cycle.
			line_counts <= '0;
			base_counts <= '0;
		end else begin
			saturated <= saturated | any_full; // sticky until next start.
			if (busy) begin
				for (int i = 0; i < `XC_NUM_LINES; i++) begin
					if (pulse[i] && !line_full[i]) begin
						line_counts[i] <= line_counts[i] + 1'b1;
					end
				end
				for (int k = 0; k < `XC_NUM_BASELINES; k++) begin
					if (base_hit[k] && !base_full[k]) begin
						base_counts[k] <= base_counts[k] + 1'b1;
					end
				end
				if (remain == '0) begin
					busy <= 1'b0;
					done <= 1'b1;
				end else begin
					remain <= remain - 1'b1;
				end
			end
		end
	end

endmodule

//--- design/pulse_sampler.sv
/*
 * Detector front end.
 * Brings the asynchronous detector lines into the intclk domain, applies
 * the per-line invert mask and turns every rising edge of the result into
 * a one-cycle pulse. Latency from line_in to pulse is three cycles.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module pulse_sampler (
	input  logic               intclk,
	input  logic               rst_n,
	input  xc_pkg::line_mask_t line_in,
	input  xc_pkg::line_mask_t invert_mask,
	output xc_pkg::line_mask_t pulse
);
	import xc_pkg::*;

	line_mask_t sync_q [`XC_SYNC_STAGES];
	line_mask_t level;
	line_mask_t level_q;

	assign level = sync_q[`XC_SYNC_STAGES-1] ^ invert_mask; // polarity per line.

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `XC_SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
			level_q <= '0;
			pulse <= '0;
		end else begin
			sync_q[0] <= line_in;
			for (int i = 1; i < `XC_SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
			level_q <= level;
			pulse <= level & ~level_q; // rising edge only.
		end
	end

endmodule

//--- design/xc_defines.svh
/*
 * Build-time sizes for the photon-pulse correlator.
 * Included by the package and by every module that sizes ports or
 * loops from these values.
 */
`ifndef XC_DEFINES_SVH
`define XC_DEFINES_SVH

`define XC_NUM_LINES 4
// one counter per unordered line pair.
`define XC_NUM_BASELINES 6

`define XC_COUNT_W 24
`define XC_SYNC_STAGES 2
`define XC_LEN_W 24

`endif

//--- design/xc_pkg.sv
/*
 * Shared types of the correlator.
 * Holds the line mask, counter and window length types, and the word
 * addresses of the host register map.
 */
`include "xc_defines.svh"

package xc_pkg;

	typedef logic [`XC_NUM_LINES-1:0] line_mask_t;
	typedef logic [`XC_COUNT_W-1:0] count_t;
	typedef logic [`XC_LEN_W-1:0] len_t;

	// word addresses seen on wb_adr.
	typedef enum logic [3:0] {
		REG_CTRL = 4'd0, REG_LEN = 4'd1, REG_INVERT = 4'd2, REG_CONFIG = 4'd3,
		REG_LINE0 = 4'd4, REG_LINE1 = 4'd5, REG_LINE2 = 4'd6, REG_LINE3 = 4'd7,
		REG_BASE0 = 4'd8, REG_BASE1 = 4'd9, REG_BASE2 = 4'd10,
		REG_BASE3 = 4'd11, REG_BASE4 = 4'd12, REG_BASE5 = 4'd13
	} reg_addr_t;

endpackage

//--- design/xc_regs.sv
/*
 * Host register file on a Wishbone classic slave.
 * Every cycle with cyc and stb gets ack on the next edge, with no wait
 * states. Holds the window length and invert mask, pulses start on a
 * CTRL write, and returns status, configuration and the frozen counts.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module xc_regs (
	input  logic                                   intclk,
	input  logic                                   rst_n,
	input  logic                                   wb_cyc,
	input  logic                                   wb_stb,
	input  logic                                   wb_we,
	input  logic [3:0]                             wb_adr,
	input  logic [31:0]                            wb_dat_i,
	output logic [31:0]                            wb_dat_o,
	output logic                                   wb_ack,
	input  logic                                   busy,
	input  logic                                   done,
	input  logic                                   saturated,
	input  xc_pkg::count_t [`XC_NUM_LINES-1:0]     line_counts,
	input  xc_pkg::count_t [`XC_NUM_BASELINES-1:0] base_counts,
	output logic                                   start,
	output xc_pkg::len_t                           integ_len,
	output xc_pkg::line_mask_t                     invert_mask
);
	import xc_pkg::*;

	// line count in the low byte, counter width above it.
	localparam logic [31:0] config_word = {16'h0000, 8'(`XC_COUNT_W), 8'(`XC_NUM_LINES)};

	reg_addr_t   addr;
	logic        req;
	logic        wr;
	logic [31:0] rd_data;

	assign addr = reg_addr_t'(wb_adr);
	assign req = wb_cyc & wb_stb & ~wb_ack; // one ack per access.
	assign wr = req & wb_we;

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			start <= 1'b0;
			integ_len <= '0;
			invert_mask <= '0;
		end else begin
			wb_ack <= req;
			start <= wr && (addr == REG_CTRL) && wb_dat_i[0];
			if (wr && !busy) begin
				case (addr)
					REG_LEN: integ_len <= wb_dat_i[`XC_LEN_W-1:0];
					REG_INVERT: invert_mask <= wb_dat_i[`XC_NUM_LINES-1:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		rd_data = '0;
		case (addr)
			REG_CTRL: rd_data = {29'd0, saturated, done, busy};
			REG_LEN: rd_data = 32'(integ_len);
			REG_INVERT: rd_data = 32'(invert_mask);
			REG_CONFIG: rd_data = config_word;
			REG_LINE0, REG_LINE1, REG_LINE2, REG_LINE3:
				rd_data = 32'(line_counts[wb_adr[1:0]]);
			REG_BASE0, REG_BASE1, REG_BASE2, REG_BASE3, REG_BASE4, REG_BASE5:
				rd_data = 32'(base_counts[wb_adr[2:0]]); // 8..13 map to 0..5.
			default: rd_data = '0;
		endcase
	end

	// read data captured on the ack edge.
	always_ff @(posedge intclk) begin
		if (req) begin
			wb_dat_o <= rd_data;
		end
	end

endmodule

//--- design/xc_top.sv
/*
 * Correlator top level.
 * Connects the detector front end, the correlator core and the
 * Wishbone register file. The host sees only the bus and line_in.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module xc_top (
	input  logic               intclk,
	input  logic               rst_n,
	input  xc_pkg::line_mask_t line_in,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  logic [3:0]         wb_adr,
	input  logic [31:0]        wb_dat_i,
	output logic [31:0]        wb_dat_o,
	output logic               wb_ack
);
	import xc_pkg::*;

	logic                                  start;
	len_t                                  integ_len;
	line_mask_t                            invert_mask;
	line_mask_t                            pulse;
	logic                                  busy;
	logic                                  done;
	logic                                  saturated;
	count_t [`XC_NUM_LINES-1:0]            line_counts;
	count_t [`XC_NUM_BASELINES-1:0]        base_counts;

	pulse_sampler i_pulse_sampler (
		.intclk(intclk), .rst_n(rst_n), .line_in(line_in),
		.invert_mask(invert_mask), .pulse(pulse)
	);

	correlator_core i_correlator_core (
		.intclk(intclk), .rst_n(rst_n), .start(start), .integ_len(integ_len),
		.pulse(pulse), .busy(busy), .done(done), .saturated(saturated),
		.line_counts(line_counts), .base_counts(base_counts)
	);

	xc_regs i_xc_regs (
		.intclk(intclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack(wb_ack), .busy(busy), .done(done), .saturated(saturated),
		.line_counts(line_counts), .base_counts(base_counts), .start(start),
		.integ_len(integ_len), .invert_mask(invert_mask)
	);

endmodule

//--- verif/xc_checker.sv
/*
 * Assertions on the Wishbone handshake and the correlator counters.
 * Bound to xc_top by the testbench.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module xc_checker (
	input logic                                   intclk,
	input logic                                   rst_n,
	input logic                                   wb_cyc,
	input logic                                   wb_stb,
	input logic                                   wb_ack,
	input logic                                   start,
	input logic                                   busy,
	input logic                                   done,
	input xc_pkg::count_t [`XC_NUM_LINES-1:0]     line_counts,
	input xc_pkg::count_t [`XC_NUM_BASELINES-1:0] base_counts
);

	ack_in_cycle: assert property (@(posedge intclk) disable iff (!rst_n)
		wb_ack |-> (wb_cyc && wb_stb))
		else $error("wb_ack high without wb_cyc and wb_stb");

	ack_single: assert property (@(posedge intclk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high on two consecutive cycles");

	// a start outside a window clears the counts.
	counts_hold: assert property (@(posedge intclk) disable iff (!rst_n)
		(!busy && !start) |=> ($stable(line_counts) && $stable(base_counts)))
		else $error("counts changed while the correlator was idle");

	busy_done_excl: assert property (@(posedge intclk) disable iff (!rst_n)
		!(busy && done))
		else $error("busy and done high together");

endmodule

//--- verif/xc_tb.sv
/*
 * Directed testbench for the photon-pulse correlator.
 * Drives the detector lines and the Wishbone bus of xc_top, predicts the
 * line and pair counts from the edges it drives and compares on readback.
 */
`timescale 1ns/1ps
`include "xc_defines.svh"

module xc_tb;
	import xc_pkg::*;

	logic        intclk;
	logic        rst_n;
	line_mask_t  line_in;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [3:0]  wb_adr;
	logic [31:0] wb_dat_i;
	logic [31:0] wb_dat_o;
	logic        wb_ack;

	int cycles = 0;
	int checks = 0;
	int errors = 0;
	bit reported = 1'b0;
	int exp_line [`XC_NUM_LINES];
	int exp_base [`XC_NUM_BASELINES];

	xc_top i_xc_top (
		.intclk(intclk), .rst_n(rst_n), .line_in(line_in), .wb_cyc(wb_cyc),
		.wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o), .wb_ack(wb_ack)
	);

	bind xc_top xc_checker i_xc_checker (
		.intclk(intclk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb),
		.wb_ack(wb_ack), .start(start), .busy(busy), .done(done),
		.line_counts(line_counts), .base_counts(base_counts)
	);

	initial begin
		intclk = 1'b0;
		forever #20 intclk = ~intclk;
	end

	// five windows of at most 400 cycles plus bus polling stay far below this.
	always @(posedge intclk) begin
		cycles++;
		if (cycles >= 20000) begin
			reported = 1'b1;
			$display("timeout: run exceeded 20000 cycles");
			$display("RESULT: FAIL");
			$finish;
		end
	end

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// called at 2 ns after an edge, returns at the same phase.
	task automatic wb_write(input logic [3:0] adr, input logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_dat_i = data;
		do begin
			@(posedge intclk);
			#2;
		end while (!wb_ack);
		@(posedge intclk); // edge that samples ack.
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input logic [3:0] adr, output logic [31:0] data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		do begin
			@(posedge intclk);
			#2;
		end while (!wb_ack);
		data = wb_dat_o;
		@(posedge intclk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic clear_expected();
		for (int i = 0; i < `XC_NUM_LINES; i++) exp_line[i] = 0;
		for (int k = 0; k < `XC_NUM_BASELINES; k++) exp_base[k] = 0;
	endtask

	// pairs counted in order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3).
	task automatic record_edges(input line_mask_t rose);
		int k;
		k = 0;
		for (int a = 0; a < `XC_NUM_LINES; a++) begin
			if (rose[a]) exp_line[a]++;
			for (int b = a + 1; b < `XC_NUM_LINES; b++) begin
				if (rose[a] && rose[b]) exp_base[k]++;
				k++;
			end
		end
	endtask

	// lines in rising go active for 3 cycles, then idle for 4.
	task automatic drive_burst(input line_mask_t rising, input line_mask_t idle);
		line_in = idle ^ rising;
		record_edges(rising);
		repeat (3) @(posedge intclk);
		#2;
		line_in = idle;
		repeat (4) @(posedge intclk);
		#2;
	endtask

	task automatic start_window(input int len);
		clear_expected();
		wb_write(REG_LEN, 32'(len));
		wb_write(REG_CTRL, 32'd1);
	endtask

	task automatic wait_idle();
		logic [31:0] status;
		status = 32'd1;
		while (status[0]) wb_read(REG_CTRL, status);
	endtask

	task automatic compare_counts(input string test);
		logic [31:0] value;
		for (int i = 0; i < `XC_NUM_LINES; i++) begin
			wb_read(4'(int'(REG_LINE0) + i), value);
			check($sformatf("%s line%0d", test, i), 32'(exp_line[i]), value);
		end
		for (int k = 0; k < `XC_NUM_BASELINES; k++) begin
			wb_read(4'(int'(REG_BASE0) + k), value);
			check($sformatf("%s base%0d", test, k), 32'(exp_base[k]), value);
		end
	endtask

	task automatic after_reset_values();
		logic [31:0] value;
		wb_read(REG_CONFIG, value);
		check("reset config", (32'd24 << 8) | 32'd4, value);
		wb_read(REG_CTRL, value);
		check("reset ctrl", 32'd0, value);
		clear_expected();
		compare_counts("reset");
	endtask

	task automatic line_counting();
		int held [`XC_NUM_LINES];
		int gap [`XC_NUM_LINES];
		line_mask_t level;
		line_mask_t rose;
		logic [31:0] value;
		level = '0;
		for (int i = 0; i < `XC_NUM_LINES; i++) begin
			held[i] = 0;
			gap[i] = 3;
		end
		start_window(400);
		for (int c = 0; c < 390; c++) begin
			rose = '0;
			for (int i = 0; i < `XC_NUM_LINES; i++) begin
				if (level[i]) begin
					held[i]++;
					if (held[i] == 3) begin
						level[i] = 1'b0;
						gap[i] = 0;
					end
				end else begin
					gap[i]++;
					if (c >= 10 && c <= 380 && gap[i] >= 3 && ($urandom % 3) == 0) begin
						level[i] = 1'b1;
						held[i] = 0;
						rose[i] = 1'b1;
					end
				end
			end
			record_edges(rose);
			line_in = level;
			@(posedge intclk);
			#2;
		end
		wait_idle();
		compare_counts("lines");
		wb_read(REG_CTRL, value);
		check("lines ctrl", 32'd2, value); // done only.
	endtask

	task automatic pair_coincidence();
		start_window(200);
		repeat (10) @(posedge intclk);
		#2;
		drive_burst(4'b0011, 4'b0000);
		drive_burst(4'b0101, 4'b0000);
		drive_burst(4'b1111, 4'b0000);
		drive_burst(4'b1001, 4'b0000);
		drive_burst(4'b0110, 4'b0000);
		drive_burst(4'b1010, 4'b0000);
		drive_burst(4'b1100, 4'b0000);
		drive_burst(4'b0111, 4'b0000);
		wait_idle();
		compare_counts("coincidence");
	endtask

	task automatic line_inversion();
		line_mask_t inv;
		logic [31:0] value;
		inv = 4'b1010;
		wb_write(REG_INVERT, 32'(inv));
		line_in = inv; // inverted lines rest high.
		repeat (6) @(posedge intclk);
		#2;
		start_window(200);
		repeat (10) @(posedge intclk);
		#2;
		drive_burst(4'b0010, inv);
		drive_burst(4'b1000, inv);
		drive_burst(4'b1010, inv);
		drive_burst(4'b0101, inv);
		drive_burst(4'b1111, inv);
		drive_burst(4'b0011, inv);
		wait_idle();
		compare_counts("inversion");
		wb_read(REG_INVERT, value);
		check("inversion mask", 32'(inv), value);
		line_in = '0;
		wb_write(REG_INVERT, 32'd0);
	endtask

	task automatic busy_writes_ignored();
		logic [31:0] value;
		start_window(300);
		wb_write(REG_LEN, 32'd55);
		wb_read(REG_LEN, value);
		check("busy len", 32'd300, value);
		drive_burst(4'b0001, 4'b0000);
		drive_burst(4'b0001, 4'b0000);
		wb_write(REG_CTRL, 32'd1); // restart while busy.
		drive_burst(4'b0001, 4'b0000);
		wait_idle();
		compare_counts("busy restart");
		start_window(50);
		wb_read(REG_CTRL, value);
		check("new start ctrl", 32'd1, value);
		wb_read(REG_LINE0, value);
		check("new start line0", 32'd0, value);
		wait_idle();
		wb_read(REG_CTRL, value);
		check("new start done", 32'd2, value);
	endtask

	initial begin
		rst_n = 1'b0;
		line_in = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_i = '0;
		void'($urandom(75472));
		repeat (8) @(posedge intclk);
		#2;
		rst_n = 1'b1;
		@(posedge intclk);
		#2;
		after_reset_values();
		line_counting();
		pair_coincidence();
		line_inversion();
		busy_writes_ignored();
		reported = 1'b1;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// reached when the run ends without the closing line.
	final begin
		if (!reported) begin
			$display("run stopped before all tests completed");
			$display("RESULT: FAIL");
		end
	end

endmodule

//--- vlog.f
+incdir+design
design/xc_pkg.sv
design/pulse_sampler.sv
design/correlator_core.sv
design/xc_regs.sv
design/xc_top.sv
verif/xc_checker.sv
verif/xc_tb.sv
